//--- flist.f
+incdir+include
hw/vm16_pkg.sv
hw/vm16_bram.sv
hw/vm16_decoder.sv
hw/vm16_regfile.sv
hw/vm16_alu.sv
hw/vm16_core_ctrl.sv
hw/vm16_mmu.sv
hw/vm16_gpio_apb.sv
hw/vm16_top.sv
verif/vm16_mmu_assertions.sv
verif/vm16_tb.sv

//--- hw/vm16_alu.sv
// Combinational ALU
// a is the rd operand, b the register or immediate operand
module vm16_alu
    import vm16_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   c
);

    always_comb begin
        case (op)
            // Moves and address generation pass the second operand
            ALU_LW,
            ALU_SW,
            ALU_MOV,
            ALU_MOVI:  c = b;
            ALU_OR:    c = a | b;
            ALU_XOR:   c = a ^ b;
            ALU_AND:   c = a & b;
            ALU_NOT:   c = ~b;
            ALU_LSHFT: c = a << b;
            ALU_RSHFT: c = a >> b;
            ALU_UADD,
            ALU_UADDI: c = a + b;
            ALU_USUB:  c = a - b;
            default:   c = '0;
        endcase
    end

endmodule

//--- hw/vm16_bram.sv
// Synchronous single-port memory
// Serves as instruction memory and as the scratch memory
module vm16_bram
    import vm16_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    wdata,
    input  logic                     we,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    // Write cycles keep the previous read word on the output
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/vm16_core_ctrl.sv
// Core control: five-state instruction sequence, program counter,
// instruction register and operand latches around decoder, registers and ALU
module vm16_core_ctrl
    import vm16_pkg::*;
#(
    parameter int ROM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  word_t                        instr_word,
    output logic [$clog2(ROM_DEPTH)-1:0] pc,
    output logic [7:0]                   dbug_pc,
    output mem_req_t                     mem_req,
    output logic                         req,
    input  logic                         busy,
    input  word_t                        mem_rdata
);

    localparam int PC_W = $clog2(ROM_DEPTH);

    typedef enum logic [2:0] {S_IF, S_R1, S_R2, S_ME, S_WB} state_e;

    state_e          state;
    logic [PC_W-1:0] pc_q;
    logic            req_q;
    instr_t          instr_q;
    dec_t            dec;
    word_t           rdd_q;
    word_t           rda_q;
    reg_sel_t        rsel;
    word_t           reg_rdata;
    logic            reg_we;
    word_t           reg_wdata;
    word_t           alu_c;

    // Single read port shared over R1 and R2
    always_comb begin
        case (state)
            S_R2:    rsel = instr_q.r.ra;
            default: rsel = instr_q.r.rd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IF;
            pc_q  <= '0;
            req_q <= 1'b0;
        end else begin
            case (state)
                S_IF: begin
                    // Counter parks on the last instruction
                    if (pc_q < PC_W'(ROM_DEPTH - 1)) begin
                        pc_q <= pc_q + 1'b1;
                    end
                    state <= S_R1;
                end
                S_R1: state <= S_R2;
                S_R2: begin
                    if (dec.has_mem) begin
                        req_q <= 1'b1;
                        state <= S_ME;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_ME: begin
                    req_q <= 1'b0;
                    if (!busy) begin
                        state <= S_WB;
                    end
                end
                default: state <= S_IF;
            endcase
        end
    end

    // Instruction and operand latches
    always_ff @(posedge clk) begin
        case (state)
            S_IF: instr_q <= instr_word;
            S_R1: rdd_q <= reg_rdata;
            S_R2: rda_q <= dec.has_imm8 ? word_t'(instr_q.i.imm8) : reg_rdata;
            default: ;
        endcase
    end

    vm16_decoder u_dec (
        .instr (instr_q),
        .dec   (dec)
    );

    vm16_regfile u_regs (
        .clk   (clk),
        .reset (reset),
        .rsel  (rsel),
        .rdata (reg_rdata),
        .we    (reg_we),
        .wsel  (instr_q.r.rd),
        .wdata (reg_wdata)
    );

    vm16_alu u_alu (
        .op (dec.alu_op),
        .a  (rdd_q),
        .b  (rda_q),
        .c  (alu_c)
    );

    assign reg_we    = dec.has_we && (state == S_WB);
    assign reg_wdata = dec.has_mem ? mem_rdata : alu_c;

    // Latches hold steady from R2 until write-back, so the request is stable
    assign mem_req.addr  = alu_c + word_t'(instr_q.r.simm5);
    assign mem_req.wdata = rdd_q;
    assign mem_req.we    = dec.has_mem_we;
    assign req           = req_q;

    assign pc      = pc_q;
    assign dbug_pc = 8'(pc_q);

endmodule

//--- hw/vm16_decoder.sv
// Instruction decoder
// Maps opcode and sub-function to an ALU operation and control flags
module vm16_decoder
    import vm16_pkg::*;
(
    input  instr_t instr,
    output dec_t   dec
);

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_NOP;
        case (instr.r.opcode)
            OP_LW: begin
                dec.alu_op  = ALU_LW;
                dec.has_we  = 1'b1;
                dec.has_mem = 1'b1;
            end
            OP_SW: begin
                dec.alu_op     = ALU_SW;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                dec.alu_op = ALU_MOV;
                dec.has_we = 1'b1;
            end
            OP_MOVI: begin
                dec.alu_op   = ALU_MOVI;
                dec.has_we   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            OP_BIT: begin
                dec.has_we = 1'b1;
                case (instr.r.simm5)
                    BIT_OR:    dec.alu_op = ALU_OR;
                    BIT_XOR:   dec.alu_op = ALU_XOR;
                    BIT_AND:   dec.alu_op = ALU_AND;
                    BIT_NOT:   dec.alu_op = ALU_NOT;
                    BIT_LSHFT: dec.alu_op = ALU_LSHFT;
                    BIT_RSHFT: dec.alu_op = ALU_RSHFT;
                    default:   dec.alu_op = ALU_BAD;
                endcase
            end
            OP_ARITH_U: begin
                dec.has_we = 1'b1;
                case (instr.r.simm5)
                    ARITH_UADD:  dec.alu_op = ALU_UADD;
                    ARITH_USUB:  dec.alu_op = ALU_USUB;
                    ARITH_UADDI: dec.alu_op = ALU_UADDI;
                    default:     dec.alu_op = ALU_BAD;
                endcase
            end
            // HALT and unknown opcodes fall through as no-ops
            default: dec.alu_op = ALU_NOP;
        endcase
    end

endmodule

//--- hw/vm16_gpio_apb.sv
// APB slave with a single GPIO output register
module vm16_gpio_apb
    import vm16_pkg::*;
#(
    parameter int GPIO_W = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  apb_req_t          apb_req,
    output apb_rsp_t          apb_rsp,
    output logic [GPIO_W-1:0] gpio
);

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio <= '0;
        end else if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
            gpio <= apb_req.pwdata[GPIO_W-1:0];
        end
    end

    // Zero wait states, any address hits this register
    assign apb_rsp.prdata = word_t'(gpio);
    assign apb_rsp.pready = apb_req.psel & apb_req.penable;

endmodule

//--- hw/vm16_mmu.sv
// Memory unit: scratch window below SCRATCH_DEPTH,
// every other address goes out through a three-state APB master
module vm16_mmu
    import vm16_pkg::*;
#(
    parameter int SCRATCH_DEPTH = 64
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  mem_req_t mem_req,
    output logic     busy,
    output word_t    rdata,
    output apb_req_t apb_req,
    input  apb_rsp_t apb_rsp
);

    localparam int SCR_AW = $clog2(SCRATCH_DEPTH);

    typedef enum logic [1:0] {APB_IDLE, APB_ACCESS, APB_DONE} apb_state_e;

    apb_state_e state;
    logic       in_scratch;
    logic       scratch_we;
    word_t      scratch_rdata;
    word_t      apb_rdata_q;

    assign in_scratch = mem_req.addr < word_t'(SCRATCH_DEPTH);
    assign scratch_we = req && in_scratch && mem_req.we;

    // Scratch accesses are busy only in the request cycle
    assign busy  = req || (state != APB_IDLE);
    assign rdata = in_scratch ? scratch_rdata : apb_rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= APB_IDLE;
            apb_req <= '0;
        end else begin
            case (state)
                APB_IDLE: begin
                    // Setup phase
                    if (req && !in_scratch) begin
                        apb_req.paddr  <= mem_req.addr;
                        apb_req.pwdata <= mem_req.wdata;
                        apb_req.pwrite <= mem_req.we;
                        apb_req.psel   <= 1'b1;
                        state          <= APB_ACCESS;
                    end
                end
                APB_ACCESS: begin
                    apb_req.penable <= 1'b1;
                    if (apb_rsp.pready) begin
                        state <= APB_DONE;
                    end
                end
                APB_DONE: begin
                    apb_req <= '0;
                    state   <= APB_IDLE;
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // Slave word captured as the transfer closes
    always_ff @(posedge clk) begin
        if (state == APB_DONE) begin
            apb_rdata_q <= apb_rsp.prdata;
        end
    end

    vm16_bram #(
        .DEPTH (SCRATCH_DEPTH)
    ) u_scratch (
        .clk   (clk),
        .addr  (mem_req.addr[SCR_AW-1:0]),
        .wdata (mem_req.wdata),
        .we    (scratch_we),
        .rdata (scratch_rdata)
    );

endmodule

//--- hw/vm16_pkg.sv
// ISA package for the 16-bit multicycle core
// Opcodes, ALU operations, instruction layouts and bus structs
package vm16_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    // NOP stays at zero so a cleared memory runs as no-ops
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h07,
        OP_MOVI    = 5'h08,
        OP_ARITH_U = 5'h0a,
        OP_HALT    = 5'h1f
    } opcode_e;

    // Sub-functions selected by the simm5 field
    typedef enum logic [4:0] {
        BIT_OR    = 5'h00,
        BIT_XOR   = 5'h01,
        BIT_AND   = 5'h02,
        BIT_NOT   = 5'h03,
        BIT_LSHFT = 5'h04,
        BIT_RSHFT = 5'h05
    } bit_fn_e;

    typedef enum logic [4:0] {
        ARITH_UADD  = 5'h00,
        ARITH_USUB  = 5'h01,
        ARITH_UADDI = 5'h02
    } arith_fn_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_LW, ALU_SW, ALU_MOV, ALU_MOVI,
        ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT,
        ALU_UADD, ALU_USUB, ALU_UADDI, ALU_BAD
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_sel_t   rd;
        reg_sel_t   ra;
        logic [4:0] simm5;
    } instr_reg_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_sel_t   rd;
        logic [7:0] imm8;
    } instr_imm_t;

    // Same word seen as register form or immediate form
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    has_imm8;
        logic    has_we;
        logic    has_mem;
        logic    has_mem_we;
    } dec_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        word_t paddr;
        logic  pwrite;
        logic  psel;
        logic  penable;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

    typedef struct packed {
        logic       we;
        logic [5:0] addr;
        word_t      data;
    } prog_wr_t;

endpackage

//--- hw/vm16_regfile.sv
// Eight-entry register file
// One asynchronous read port, one synchronous write port
module vm16_regfile
    import vm16_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_sel_t rsel,
    output word_t    rdata,
    input  logic     we,
    input  reg_sel_t wsel,
    input  word_t    wdata
);

    word_t regs [NUM_REGS];

    // Register i comes out of reset holding i
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= word_t'(i);
            end
        end else if (we) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdata = regs[rsel];

endmodule

//--- hw/vm16_top.sv
// Microcontroller top: instruction memory, core, memory unit and GPIO slave
module vm16_top
    import vm16_pkg::*;
#(
    parameter int ROM_DEPTH     = 64,
    parameter int SCRATCH_DEPTH = 64,
    parameter int GPIO_W        = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  prog_wr_t          prog,
    output logic [GPIO_W-1:0] gpio,
    output logic [7:0]        dbug_pc
);

    localparam int ROM_AW = $clog2(ROM_DEPTH);

    logic [ROM_AW-1:0] pc;
    logic [ROM_AW-1:0] rom_addr;
    word_t             instr_word;
    mem_req_t          mem_req;
    logic              req;
    logic              busy;
    word_t             mem_rdata;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    // Program port owns the instruction memory while loading
    assign rom_addr = prog.we ? prog.addr[ROM_AW-1:0] : pc;

    vm16_bram #(
        .DEPTH (ROM_DEPTH)
    ) u_rom (
        .clk   (clk),
        .addr  (rom_addr),
        .wdata (prog.data),
        .we    (prog.we),
        .rdata (instr_word)
    );

    vm16_core_ctrl #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .instr_word (instr_word),
        .pc         (pc),
        .dbug_pc    (dbug_pc),
        .mem_req    (mem_req),
        .req        (req),
        .busy       (busy),
        .mem_rdata  (mem_rdata)
    );

    vm16_mmu #(
        .SCRATCH_DEPTH (SCRATCH_DEPTH)
    ) u_mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .mem_req (mem_req),
        .busy    (busy),
        .rdata   (mem_rdata),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    vm16_gpio_apb #(
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .gpio    (gpio)
    );

endmodule

//--- verif/vm16_mmu_assertions.sv
// APB protocol and request handshake checks for the memory unit
module vm16_mmu_assertions
    import vm16_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     req,
    input logic     busy,
    input apb_req_t apb_req
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) apb_req.penable |-> apb_req.psel
    ) else begin
        fail_count++;
        $error("penable high without psel");
    end

    // Address and direction hold for the whole transfer
    apb_ctrl_stable: assert property (
        @(posedge clk) disable iff (reset)
        (apb_req.psel && $past(apb_req.psel)) |->
            ($stable(apb_req.paddr) && $stable(apb_req.pwrite))
    ) else begin
        fail_count++;
        $error("paddr or pwrite changed while psel was high");
    end

    // Longest path is the three-state APB sequence
    req_ends_busy: assert property (
        @(posedge clk) disable iff (reset) req |-> ##[1:4] !busy
    ) else begin
        fail_count++;
        $error("busy did not fall after req");
    end

endmodule

bind vm16_mmu vm16_mmu_assertions u_apb_checks (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .busy    (busy),
    .apb_req (apb_req)
);

//--- include/vm16_isa_model.svh
// Instruction-level model of the core
// Runs a program and returns the final GPIO register, zero-extended
`ifndef VM16_ISA_MODEL_SVH
`define VM16_ISA_MODEL_SVH

function automatic vm16_pkg::word_t vm16_isa_model(
    input vm16_pkg::word_t prog [],
    input int              scratch_depth,
    input int              gpio_w
);
    vm16_pkg::word_t  regs [vm16_pkg::NUM_REGS];
    vm16_pkg::word_t  scratch [vm16_pkg::word_t];
    vm16_pkg::word_t  gpio;
    vm16_pkg::word_t  a;
    vm16_pkg::word_t  b;
    vm16_pkg::word_t  addr;
    vm16_pkg::instr_t ins;

    gpio = '0;
    for (int i = 0; i < vm16_pkg::NUM_REGS; i++) begin
        regs[i] = vm16_pkg::word_t'(i);
    end
    foreach (prog[n]) begin
        ins  = prog[n];
        a    = regs[ins.r.rd];
        b    = (ins.r.opcode == vm16_pkg::OP_MOVI) ? vm16_pkg::word_t'(ins.i.imm8)
                                                   : regs[ins.r.ra];
        addr = b + vm16_pkg::word_t'(ins.r.simm5);
        case (ins.r.opcode)
            vm16_pkg::OP_MOV, vm16_pkg::OP_MOVI: regs[ins.r.rd] = b;
            vm16_pkg::OP_BIT: begin
                case (ins.r.simm5)
                    vm16_pkg::BIT_OR:    regs[ins.r.rd] = a | b;
                    vm16_pkg::BIT_XOR:   regs[ins.r.rd] = a ^ b;
                    vm16_pkg::BIT_AND:   regs[ins.r.rd] = a & b;
                    vm16_pkg::BIT_NOT:   regs[ins.r.rd] = ~b;
                    vm16_pkg::BIT_LSHFT: regs[ins.r.rd] = a << b;
                    vm16_pkg::BIT_RSHFT: regs[ins.r.rd] = a >> b;
                    default:             regs[ins.r.rd] = '0;
                endcase
            end
            vm16_pkg::OP_ARITH_U: begin
                case (ins.r.simm5)
                    vm16_pkg::ARITH_UADD, vm16_pkg::ARITH_UADDI: regs[ins.r.rd] = a + b;
                    vm16_pkg::ARITH_USUB: regs[ins.r.rd] = a - b;
                    default:              regs[ins.r.rd] = '0;
                endcase
            end
            vm16_pkg::OP_SW: begin
                if (addr < vm16_pkg::word_t'(scratch_depth)) scratch[addr] = a;
                else gpio = a & vm16_pkg::word_t'((1 << gpio_w) - 1);
            end
            vm16_pkg::OP_LW: begin
                if (addr >= vm16_pkg::word_t'(scratch_depth)) regs[ins.r.rd] = gpio;
                else regs[ins.r.rd] = scratch.exists(addr) ? scratch[addr] : '0;
            end
            default: ;
        endcase
    end
    return gpio;
endfunction

`endif

//--- verif/vm16_tb.sv
// Testbench for the 16-bit core
// Loads generated programs under reset and checks the final GPIO value
module vm16_tb
    import vm16_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_DEPTH     = 64;
    localparam int SCRATCH_DEPTH = 64;
    localparam int GPIO_W        = 8;
    localparam int RESET_CYCLES  = 8;
    // Longest instruction is an APB load or store
    localparam int INSTR_CYCLES  = 9;
    localparam int NUM_TESTS     = 20;
    localparam int TEST_CYCLES   = ROM_DEPTH * 12 + ROM_DEPTH + RESET_CYCLES;

    logic              clk;
    logic              reset;
    prog_wr_t          prog;
    logic [GPIO_W-1:0] gpio;
    logic [7:0]        dbug_pc;
    word_t             code [$];

    `include "vm16_isa_model.svh"

    vm16_top #(
        .ROM_DEPTH     (ROM_DEPTH),
        .SCRATCH_DEPTH (SCRATCH_DEPTH),
        .GPIO_W        (GPIO_W)
    ) u_vm16_top (
        .clk     (clk),
        .reset   (reset),
        .prog    (prog),
        .gpio    (gpio),
        .dbug_pc (dbug_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("Timeout: a program did not reach the last address in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    function automatic word_t encode_reg(opcode_e op, reg_sel_t rd, reg_sel_t ra,
                                         logic [4:0] fn);
        instr_t ins;
        ins.r.opcode = op;
        ins.r.rd     = rd;
        ins.r.ra     = ra;
        ins.r.simm5  = fn;
        return ins;
    endfunction

    function automatic word_t encode_imm(opcode_e op, reg_sel_t rd, logic [7:0] imm);
        instr_t ins;
        ins.i.opcode = op;
        ins.i.rd     = rd;
        ins.i.imm8   = imm;
        return ins;
    endfunction

    // Random address outside the scratch window, then a store of src to it
    task automatic append_gpio_store(input reg_sel_t src, input reg_sel_t addr_reg);
        code.push_back(encode_imm(OP_MOVI, addr_reg, 8'($urandom_range(255, SCRATCH_DEPTH))));
        code.push_back(encode_reg(OP_SW, src, addr_reg, 5'd0));
    endtask

    task automatic expect_gpio(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] gpio expected %h, actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "gpio mismatch");
        end
    endtask

    task automatic verify_pc(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] dbug_pc expected %h, actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "dbug_pc mismatch");
        end
    endtask

    // Program words then zeros, all written while reset is high
    task automatic load_program();
        reset = 1'b1;
        for (int a = 0; a < ROM_DEPTH; a++) begin
            prog.we   = 1'b1;
            prog.addr = 6'(a);
            prog.data = (a < code.size()) ? code[a] : '0;
            @(negedge clk);
        end
        prog = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_program(input string name);
        word_t program_words [];
        word_t expected;
        program_words = new[code.size()];
        foreach (code[n]) begin
            program_words[n] = code[n];
        end
        load_program();
        while (dbug_pc != 8'(ROM_DEPTH - 1)) begin
            @(negedge clk);
        end
        repeat (10 * INSTR_CYCLES) @(negedge clk);
        expected = vm16_isa_model(program_words, SCRATCH_DEPTH, GPIO_W);
        expect_gpio(name, expected, word_t'(gpio));
        verify_pc(name, 8'(ROM_DEPTH - 1), dbug_pc);
    endtask

    task automatic alu_random_test();
        reg_sel_t ra;
        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'($urandom)));
        code.push_back(encode_imm(OP_MOVI, 3'd2, 8'($urandom_range(15, 0))));
        code.push_back(encode_imm(OP_MOVI, 3'd3, 8'($urandom)));
        repeat (4) begin
            ra = ($urandom_range(1, 0) == 0) ? 3'd2 : 3'd3;
            if ($urandom_range(1, 0) == 0) begin
                code.push_back(encode_reg(OP_BIT, 3'd1, ra, 5'($urandom_range(5, 0))));
            end else begin
                code.push_back(encode_reg(OP_ARITH_U, 3'd1, ra, 5'($urandom_range(2, 0))));
            end
        end
        append_gpio_store(3'd1, 3'd7);
        run_program("alu_random");
    endtask

    task automatic scratch_roundtrip_test();
        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'($urandom)));
        code.push_back(encode_imm(OP_MOVI, 3'd2, 8'($urandom_range(SCRATCH_DEPTH - 32, 0))));
        code.push_back(encode_reg(OP_SW, 3'd1, 3'd2, 5'($urandom_range(31, 1))));
        code.push_back(encode_reg(OP_LW, 3'd3, 3'd2, code[$][4:0]));
        code.push_back(encode_reg(OP_MOV, 3'd4, 3'd3, 5'd0));
        append_gpio_store(3'd4, 3'd7);
        run_program("scratch_roundtrip");
    endtask

    initial begin
        reset = 1'b1;
        prog  = '0;
        void'($urandom(32'hd641fea2));
        @(negedge clk);

        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'($urandom)));
        append_gpio_store(3'd1, 3'd7);
        run_program("movi_sw_gpio");

        for (int i = 0; i < NUM_REGS; i++) begin
            code.delete();
            append_gpio_store(reg_sel_t'(i), reg_sel_t'(i + 1));
            run_program("reset_value");
        end

        // 3 - 200 wraps, the high byte is brought down to the pins
        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'd3));
        code.push_back(encode_imm(OP_MOVI, 3'd2, 8'd200));
        code.push_back(encode_reg(OP_ARITH_U, 3'd1, 3'd2, ARITH_USUB));
        code.push_back(encode_imm(OP_MOVI, 3'd3, 8'd8));
        code.push_back(encode_reg(OP_BIT, 3'd1, 3'd3, BIT_RSHFT));
        append_gpio_store(3'd1, 3'd7);
        run_program("sub_wrap");

        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'ha5));
        code.push_back(encode_imm(OP_MOVI, 3'd2, 8'd4));
        code.push_back(encode_reg(OP_BIT, 3'd1, 3'd2, BIT_LSHFT));
        code.push_back(encode_imm(OP_MOVI, 3'd3, 8'd6));
        code.push_back(encode_reg(OP_BIT, 3'd1, 3'd3, BIT_RSHFT));
        append_gpio_store(3'd1, 3'd7);
        run_program("shift_pair");

        repeat (6) alu_random_test();
        repeat (2) scratch_roundtrip_test();

        // Bits 11:8 of the loaded word land on the pins, zero if extended
        code.delete();
        code.push_back(encode_imm(OP_MOVI, 3'd1, 8'($urandom)));
        append_gpio_store(3'd1, 3'd7);
        code.push_back(encode_reg(OP_LW, 3'd2, 3'd7, 5'd0));
        code.push_back(encode_imm(OP_MOVI, 3'd3, 8'd4));
        code.push_back(encode_reg(OP_BIT, 3'd2, 3'd3, BIT_RSHFT));
        append_gpio_store(3'd2, 3'd6);
        run_program("gpio_readback");

        if (u_vm16_top.u_mmu.u_apb_checks.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("APB assertions failed %0d times",
                     u_vm16_top.u_mmu.u_apb_checks.fail_count);
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
